/* project.f */
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build the RV32I core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_rv_core -o tb_rv_core \
  || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/tb_rv_core)"
echo "$out"

echo "$out" | grep -q "Result: PASSED" && exit 0 || exit 1

/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data word and register file geometry
`define RV_XLEN 32
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// program counter
`define RV_RESET_PC 32'h0000_0000
`define RV_INSN_STEP 32'd4

// funct7 forms, the alternate one selects SUB and SRA/SRAI
`define RV_FUNCT7_STD 7'b000_0000
`define RV_FUNCT7_ALT 7'b010_0000

// instruction field positions
`define RV_F_OPCODE 6:0
`define RV_F_RD 11:7
`define RV_F_FUNCT3 14:12
`define RV_F_RS1 19:15
`define RV_F_RS2 24:20
`define RV_F_FUNCT7 31:25
`define RV_F_ECALL_ZERO 31:7

`endif

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_XLEN-1:0]   insn,
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  halt,
  output logic                  wb_we,
  output logic [`RV_REG_AW-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]   wb_data
);
  import rv_pkg::*;

  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_XLEN-1:0]   alu_result;
  alu_op_e               alu_op;
  branch_cond_e          branch_cond;
  logic                  use_imm;
  logic                  rd_we;
  logic                  is_ecall;
  logic                  branch_taken;

  rv_decode decode_i (
    .insn        (insn),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd          (wb_rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .branch_cond (branch_cond),
    .rd_we       (rd_we),
    .is_ecall    (is_ecall)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd       (wb_rd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_we),
    .wd       (wb_data)
  );

  rv_execute execute_i (
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .alu_op       (alu_op),
    .use_imm      (use_imm),
    .branch_cond  (branch_cond),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  // write-back goes to the register file and out as the retire port
  rv_result result_i (
    .clk          (clk),
    .rst          (rst),
    .branch_taken (branch_taken),
    .rd_we        (rd_we),
    .is_ecall     (is_ecall),
    .imm          (imm),
    .alu_result   (alu_result),
    .pc           (pc),
    .halt         (halt),
    .wb_we        (wb_we),
    .wb_data      (wb_data)
  );

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0]   insn,
  output logic [`RV_REG_AW-1:0] rs1_addr,
  output logic [`RV_REG_AW-1:0] rs2_addr,
  output logic [`RV_REG_AW-1:0] rd,
  output logic [`RV_XLEN-1:0]   imm,
  output rv_pkg::alu_op_e       alu_op,
  output logic                  use_imm,
  output rv_pkg::branch_cond_e  branch_cond,
  output logic                  rd_we,
  output logic                  is_ecall
);
  import rv_pkg::*;

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                f7_std;
  logic                f7_alt;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_b;

  assign opcode   = opcode_e'(insn[`RV_F_OPCODE]);
  assign funct3   = insn[`RV_F_FUNCT3];
  assign funct7   = insn[`RV_F_FUNCT7];
  assign rd       = insn[`RV_F_RD];
  assign rs1_addr = insn[`RV_F_RS1];
  assign rs2_addr = insn[`RV_F_RS2];

  assign f7_std = (funct7 == `RV_FUNCT7_STD);
  assign f7_alt = (funct7 == `RV_FUNCT7_ALT);

  // sign-extended immediates
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  always_comb begin
    alu_op      = ALU_ADD;
    use_imm     = 1'b0;
    imm         = imm_i;
    branch_cond = BR_NONE;
    rd_we       = 1'b0;
    is_ecall    = 1'b0;

    case (opcode)
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u;
        rd_we   = 1'b1;
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        rd_we   = 1'b1;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            // upper imm bits must be zero for a legal SLLI
            alu_op = ALU_SLL;
            rd_we  = f7_std;
          end
          default: begin
            alu_op = f7_alt ? ALU_SRA : ALU_SRL;
            rd_we  = f7_std || f7_alt;
          end
        endcase
      end
      OPC_OP: begin
        // alternate funct7 only exists for SUB and SRA
        rd_we = f7_std || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        case (funct3)
          3'b000: alu_op = f7_alt ? ALU_SUB : ALU_ADD;
          3'b001: alu_op = ALU_SLL;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b101: alu_op = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110: alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPC_BRANCH: begin
        imm = imm_b;
        case (funct3)
          3'b000: branch_cond = BR_EQ;
          3'b001: branch_cond = BR_NE;
          3'b100: branch_cond = BR_LT;
          3'b101: branch_cond = BR_GE;
          3'b110: branch_cond = BR_LTU;
          3'b111: branch_cond = BR_GEU;
          default: branch_cond = BR_NONE;
        endcase
      end
      OPC_SYSTEM: begin
        // only the all-zero form is ECALL
        is_ecall = (insn[`RV_F_ECALL_ZERO] == '0);
      end
      default: begin
      end
    endcase

    // cross-check against the raw opcode bits
    if (rd_we) begin
      assert (insn[`RV_F_OPCODE] inside {7'b011_0111, 7'b001_0011, 7'b011_0011});
    end
  end

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_execute (
  input  logic [`RV_XLEN-1:0]  rs1_data,
  input  logic [`RV_XLEN-1:0]  rs2_data,
  input  logic [`RV_XLEN-1:0]  imm,
  input  rv_pkg::alu_op_e      alu_op,
  input  logic                 use_imm,
  input  rv_pkg::branch_cond_e branch_cond,
  output logic [`RV_XLEN-1:0]  alu_result,
  output logic                 branch_taken
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                alu_lt;
  logic                alu_ltu;
  logic                br_eq;
  logic                br_lt;
  logic                br_ltu;

  // second operand is the immediate for LUI and OP-IMM
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  assign alu_lt  = $signed(rs1_data) < $signed(op_b);
  assign alu_ltu = rs1_data < op_b;

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = rs1_data + op_b;
      ALU_SUB:    alu_result = rs1_data - op_b;
      ALU_SLL:    alu_result = rs1_data << shamt;
      ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, alu_lt};
      ALU_SLTU:   alu_result = {{(`RV_XLEN-1){1'b0}}, alu_ltu};
      ALU_XOR:    alu_result = rs1_data ^ op_b;
      ALU_SRL:    alu_result = rs1_data >> shamt;
      // arithmetic shift fills with the sign bit
      ALU_SRA:    alu_result = $unsigned($signed(rs1_data) >>> shamt);
      ALU_OR:     alu_result = rs1_data | op_b;
      ALU_AND:    alu_result = rs1_data & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // branch compare always uses the two register values
  assign br_eq  = rs1_data == rs2_data;
  assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
  assign br_ltu = rs1_data < rs2_data;

  always_comb begin
    case (branch_cond)
      BR_EQ:   branch_taken = br_eq;
      BR_NE:   branch_taken = !br_eq;
      BR_LT:   branch_taken = br_lt;
      BR_GE:   branch_taken = !br_lt;
      BR_LTU:  branch_taken = br_ltu;
      BR_GEU:  branch_taken = !br_ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // major opcodes handled by the core, values as in the ISA spec
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_OP     = 7'b011_0011,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // second operand straight through, used by LUI
    ALU_PASS_B
  } alu_op_e;

  // conditional branch kinds, BR_NONE for anything that is not a branch
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } branch_cond_e;

endpackage

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic [`RV_REG_AW-1:0] rd,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data,
  input  logic                  we,
  input  logic [`RV_XLEN-1:0]   wd
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // x0 writes dropped here
      regs[rd] <= wd;
    end
  end

  // combinational read ports
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // x0 reads zero on every cycle, whatever the write stream did
  assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

`default_nettype wire

/* rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_result (
  input  logic                clk,
  input  logic                rst,
  input  logic                branch_taken,
  input  logic                rd_we,
  input  logic                is_ecall,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] pc,
  output logic                halt,
  output logic                wb_we,
  output logic [`RV_XLEN-1:0] wb_data
);

  logic [`RV_XLEN-1:0] pc_next;

  // taken branch is pc relative, everything else steps one word
  assign pc_next = branch_taken ? pc + imm : pc + `RV_INSN_STEP;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      pc   <= pc_next;
      // sticky once set, only reset clears it
      halt <= is_ecall;
    end
  end

  // no register writes once stopped
  assign wb_we   = rd_we && !halt;
  assign wb_data = alu_result;

  // branch targets from the stream must keep fetch word aligned
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_core;
  import rv_pkg::*;

  // random instructions before the final ECALL
  localparam int NUM_INSNS = 2000;
  // reset, the halt window and some margin on top of one cycle per instruction
  localparam int MAX_CYCLES = NUM_INSNS + 500;

  logic                  clk = 1'b0;
  logic                  rst;
  logic [`RV_XLEN-1:0]   insn;
  logic [`RV_XLEN-1:0]   pc;
  logic                  halt;
  logic                  wb_we;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;

  // reference state
  logic [`RV_XLEN-1:0]   shadow [`RV_NUM_REGS];
  logic [`RV_XLEN-1:0]   model_pc;
  logic                  model_halted;
  logic                  e_we;
  logic [`RV_REG_AW-1:0] e_rd;
  logic [`RV_XLEN-1:0]   e_data;
  logic [`RV_XLEN-1:0]   e_pc;
  logic                  e_stop;

  int errors;
  int checks;
  int retired;
  int halted_cycles;
  int cycles;

  rv_core dut_i (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // expected retire of one instruction, straight from the RV32I rules
  function automatic void predict_retire(
    input  logic [31:0] insn_v,
    input  logic [31:0] pc_v,
    input  logic [31:0] regs [`RV_NUM_REGS],
    output logic        exp_we,
    output logic [4:0]  exp_rd,
    output logic [31:0] exp_data,
    output logic [31:0] exp_pc,
    output logic        exp_stop
  );
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_b;
    logic        taken;

    opc   = insn_v[6:0];
    f3    = insn_v[14:12];
    f7    = insn_v[31:25];
    a     = regs[insn_v[19:15]];
    b     = regs[insn_v[24:20]];
    imm_b = {{19{insn_v[31]}}, insn_v[31], insn_v[7], insn_v[30:25], insn_v[11:8], 1'b0};
    taken = 1'b0;
    exp_we   = 1'b0;
    exp_rd   = insn_v[11:7];
    exp_data = 32'h0;
    exp_pc   = pc_v + 32'd4;
    exp_stop = 1'b0;

    case (opc)
      OPC_LUI: begin
        exp_we   = 1'b1;
        exp_data = {insn_v[31:12], 12'h000};
      end
      OPC_OP_IMM, OPC_OP: begin
        if (opc == OPC_OP) begin
          exp_we = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        end else begin
          b = {{20{insn_v[31]}}, insn_v[31:20]};
          if (f3 == 3'b001) exp_we = (f7 == 7'h00);
          else if (f3 == 3'b101) exp_we = (f7 == 7'h00 || f7 == 7'h20);
          else exp_we = 1'b1;
        end
        case (f3)
          3'b000: begin
            // only the register form has SUB
            if (opc == OPC_OP && f7 == 7'h20) exp_data = a - b;
            else exp_data = a + b;
          end
          3'b001: exp_data = a << b[4:0];
          3'b010: exp_data = {31'b0, $signed(a) < $signed(b)};
          3'b011: exp_data = {31'b0, a < b};
          3'b100: exp_data = a ^ b;
          3'b101: begin
            if (f7 == 7'h20) exp_data = $signed(a) >>> b[4:0];
            else exp_data = a >> b[4:0];
          end
          3'b110: exp_data = a | b;
          default: exp_data = a & b;
        endcase
      end
      OPC_BRANCH: begin
        case (f3)
          3'b000: taken = (a == b);
          3'b001: taken = (a != b);
          3'b100: taken = ($signed(a) < $signed(b));
          3'b101: taken = !($signed(a) < $signed(b));
          3'b110: taken = (a < b);
          3'b111: taken = !(a < b);
          default: taken = 1'b0;
        endcase
        if (taken) exp_pc = pc_v + imm_b;
      end
      OPC_SYSTEM: exp_stop = (insn_v[31:7] == 25'h0);
      default: begin
      end
    endcase
  endfunction

  // weighted mix of kept operations, odd funct7 forms and foreign opcodes
  function automatic logic [31:0] random_insn();
    int unsigned kind;
    logic [31:0] r;
    logic [31:0] s;
    logic [6:0]  f7;
    logic [12:0] off;
    logic [4:0]  rs2;
    logic [31:0] result;

    kind = $urandom_range(0, 99);
    r    = $urandom();
    s    = $urandom();
    f7   = 7'h00;
    if (s[3:0] == 4'h0) f7 = r[31:25];
    else if (s[4]) f7 = 7'h20;
    // word-aligned offset in -128..124
    off = {{6{s[8]}}, s[7:3], 2'b00};
    rs2 = s[9] ? r[19:15] : r[24:20];

    if (kind < 12) begin
      result = {r[31:7], OPC_LUI};
    end else if (kind < 42) begin
      if (r[14:12] == 3'b001 || r[14:12] == 3'b101) result = {f7, r[24:7], OPC_OP_IMM};
      else result = {r[31:7], OPC_OP_IMM};
    end else if (kind < 72) begin
      result = {f7, r[24:7], OPC_OP};
    end else if (kind < 92) begin
      result = {off[12], off[10:5], rs2, r[19:15], r[14:12], off[4:1], off[11], OPC_BRANCH};
    end else if (s[2]) begin
      // EBREAK, a SYSTEM encoding that is not ECALL
      result = 32'h0010_0073;
    end else begin
      case (s[1:0])
        2'b00: result = {r[31:7], 7'b000_0011};
        2'b01: result = {r[31:7], 7'b010_0011};
        2'b10: result = {r[31:7], 7'b110_1111};
        default: result = {r[31:7], 7'b001_0111};
      endcase
    end
    return result;
  endfunction

  // outputs settle 1 ns after the drive, compare at the falling edge
  always @(negedge clk) begin
    if (rst) begin
      check_value("pc", pc, `RV_RESET_PC);
      check_value("halt", 32'(halt), 32'h0);
      check_value("wb_we", 32'(wb_we), 32'h0);
    end else if (model_halted) begin
      halted_cycles++;
      check_value("halt", 32'(halt), 32'h1);
      check_value("pc", pc, model_pc);
      check_value("wb_we", 32'(wb_we), 32'h0);
    end else begin
      predict_retire(insn, model_pc, shadow, e_we, e_rd, e_data, e_pc, e_stop);
      check_value("pc", pc, model_pc);
      check_value("halt", 32'(halt), 32'h0);
      check_value("wb_we", 32'(wb_we), 32'(e_we));
      if (e_we) begin
        check_value("wb_rd", 32'(wb_rd), 32'(e_rd));
        check_value("wb_data", wb_data, e_data);
        if (e_rd != 5'd0) shadow[e_rd] = e_data;
      end
      model_pc     = e_pc;
      model_halted = e_stop;
      retired++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the core never finished the halt window", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc26b));
    rst           = 1'b1;
    insn          = 32'h0;
    model_pc      = `RV_RESET_PC;
    model_halted  = 1'b0;
    errors        = 0;
    checks        = 0;
    retired       = 0;
    halted_cycles = 0;
    cycles        = 0;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      shadow[i] = 32'h0;
    end

    repeat (4) @(posedge clk);
    #1;
    rst  = 1'b0;
    insn = random_insn();
    for (int i = 1; i < NUM_INSNS; i++) begin
      @(posedge clk);
      #1;
      insn = random_insn();
    end

    // ECALL goes last, then writing LUIs follow that a stopped core must ignore
    @(posedge clk);
    #1;
    insn = {25'h0, OPC_SYSTEM};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      #1;
      insn = {20'($urandom()), 5'(i + 1), OPC_LUI};
    end

    checks++;
    assert (halted_cycles >= 10) else begin
      errors++;
      $display("halt window too short, only %0d halted cycles seen", halted_cycles);
    end

    $display("errors %0d in %0d checks, %0d instructions retired, %0d halted cycles",
             errors, checks, retired, halted_cycles);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
